// ==== sources.f ====
+incdir+verification
hw/mem_pkg.sv
hw/memory_controller.sv
hw/param_fifo.sv
hw/layer_buffer.sv
hw/apb_load_port.sv
hw/cnn_mem_top.sv
verification/tb_cnn_mem_top.sv

// ==== Bender.yml ====
package:
  name: cnn_mem

sources:
  # Design, in compile order
  - files:
      - hw/mem_pkg.sv
      - hw/memory_controller.sv
      - hw/param_fifo.sv
      - hw/layer_buffer.sv
      - hw/apb_load_port.sv
      - hw/cnn_mem_top.sv

  # Testbench
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_cnn_mem_top.sv

// ==== verification/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// APB read word against the register value the host should see
task automatic rdata_check(input string what, input logic [31:0] got,
                           input logic [31:0] exp);
    check_count++;
    if (got !== exp)
    begin
        err_count++;
        $display("error at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
endtask

// Error response of one APB access
task automatic slverr_check(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
        err_count++;
        $display("error at %0t: %s pslverr %b, expected %b", $time, what, got, exp);
    end
endtask

// Ready flag in the access phase of one APB transfer
task automatic ready_check(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
        err_count++;
        $display("error at %0t: %s pready %b, expected %b", $time, what, got, exp);
    end
endtask

// One streamed parameter word
task automatic stream_check(input string what, input logic [mem_pkg::DATA_W-1:0] got,
                            input logic [mem_pkg::DATA_W-1:0] exp);
    check_count++;
    if (got !== exp)
    begin
        err_count++;
        $display("error at %0t: %s 0x%04h, expected 0x%04h", $time, what, got, exp);
    end
endtask

`endif

// ==== verification/tb_cnn_mem_top.sv ====
`timescale 1ns/1ps

module tb_cnn_mem_top;

    localparam int CLK_PERIOD = 100;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_STREAM} op_t;

    // Table row with the read-state length in hold for stream rows
    typedef struct packed {
        logic [3:0]  test;
        op_t         op;
        logic [7:0]  addr;
        logic [31:0] data;
        logic        exp_err;
        logic [31:0] exp_rdata;
        logic [7:0]  hold;
    } row_t;

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [7:0]                 paddr;
    logic [31:0]                pwdata;
    logic [31:0]                prdata;
    logic                       pready;
    logic                       pslverr;
    mem_pkg::state_t            read_state;
    logic [mem_pkg::DATA_W-1:0] bias_q;
    logic                       bias_valid;
    logic [mem_pkg::DATA_W-1:0] weight_q;
    logic                       weight_valid;
    logic [mem_pkg::DATA_W-1:0] layer_q;
    logic                       layer_valid;

    row_t                       rows[$];
    logic [mem_pkg::DATA_W-1:0] bias_exp[$];
    logic [mem_pkg::DATA_W-1:0] weight_exp[$];
    logic [mem_pkg::DATA_W-1:0] layer_exp[$];
    int                         err_count = 0;
    int                         check_count = 0;
    int                         seed = 89;
    bit                         table_ready = 1'b0;

    `include "tb_checks.svh"

    cnn_mem_top UUT (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .read_state   (read_state),
        .bias_q       (bias_q),
        .bias_valid   (bias_valid),
        .weight_q     (weight_q),
        .weight_valid (weight_valid),
        .layer_q      (layer_q),
        .layer_valid  (layer_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Table helpers
    //////////////////////////////

    // Status layout with load done in bit 4 above the four store flags
    function automatic logic [31:0] status_word(input logic done, input logic bf,
                                                input logic be, input logic wf,
                                                input logic we);
        status_word = '0;
        status_word[mem_pkg::STATUS_LOAD_DONE] = done;
        status_word[3:0] = {bf, be, wf, we};
    endfunction

    function automatic bit is_data_addr(input logic [7:0] addr);
        return addr == mem_pkg::ADDR_BIAS_DATA || addr == mem_pkg::ADDR_WEIGHT_DATA
               || addr == mem_pkg::ADDR_LAYER_DATA;
    endfunction

    function automatic string test_name(input logic [3:0] test);
        case (test)
            1:       return "reset state";
            2:       return "bias only load";
            3:       return "bias fifo full";
            4:       return "weight load and stream";
            5:       return "layer load and replay";
            default: return "clear and bad address";
        endcase
    endfunction

    task automatic write_row(input logic [3:0] test, input logic [7:0] addr,
                             input logic [31:0] data, input logic exp_err);
        row_t r;
        r = '0;
        r.test = test;
        r.op = OP_WRITE;
        r.addr = addr;
        r.data = data;
        r.exp_err = exp_err;
        rows.push_back(r);
    endtask

    task automatic read_row(input logic [3:0] test, input logic [7:0] addr,
                            input logic exp_err, input logic [31:0] exp_rdata);
        row_t r;
        r = '0;
        r.test = test;
        r.op = OP_READ;
        r.addr = addr;
        r.exp_err = exp_err;
        r.exp_rdata = exp_rdata;
        rows.push_back(r);
    endtask

    task automatic stream_row(input logic [3:0] test, input mem_pkg::state_t state,
                              input logic [7:0] hold);
        row_t r;
        r = '0;
        r.test = test;
        r.op = OP_STREAM;
        r.data[2:0] = state;
        r.hold = hold;
        rows.push_back(r);
    endtask

    //////////////////////////////
    // Stimulus table
    //////////////////////////////

    // Data writes take a fresh random word when applied
    task automatic build_table();
        read_row(1, mem_pkg::ADDR_STATUS, 1'b0, status_word(1, 0, 1, 0, 1));
        read_row(1, mem_pkg::ADDR_LOAD_STATE, 1'b0, 32'h0);

        write_row(2, mem_pkg::ADDR_LOAD_STATE, 32'h4, 1'b0);
        for (int i = 0; i < 3; i++)
            write_row(2, mem_pkg::ADDR_BIAS_DATA, 32'h0, 1'b0);
        write_row(2, mem_pkg::ADDR_WEIGHT_DATA, 32'h0, 1'b1);
        stream_row(2, 3'b010, 6);

        for (int i = 0; i < 5; i++)
            write_row(3, mem_pkg::ADDR_BIAS_DATA, 32'h0, 1'b0);
        write_row(3, mem_pkg::ADDR_BIAS_DATA, 32'h0, 1'b1);
        read_row(3, mem_pkg::ADDR_STATUS, 1'b0, status_word(0, 1, 0, 0, 1));

        write_row(4, mem_pkg::ADDR_LOAD_STATE, 32'h2, 1'b0);
        for (int i = 0; i < 6; i++)
            write_row(4, mem_pkg::ADDR_WEIGHT_DATA, 32'h0, 1'b0);
        write_row(4, mem_pkg::ADDR_LOAD_STATE, 32'h0, 1'b0);
        read_row(4, mem_pkg::ADDR_STATUS, 1'b0, status_word(1, 1, 0, 0, 0));
        stream_row(4, 3'b110, 20);
        read_row(4, mem_pkg::ADDR_STATUS, 1'b0, status_word(1, 0, 1, 0, 1));

        write_row(5, mem_pkg::ADDR_LOAD_STATE, 32'h1, 1'b0);
        for (int i = 0; i < 5; i++)
            write_row(5, mem_pkg::ADDR_LAYER_DATA, 32'h0, 1'b0);
        write_row(5, mem_pkg::ADDR_LOAD_STATE, 32'h0, 1'b0);
        // Layer buffer has no empty flag, so read exactly what was written
        stream_row(5, 3'b001, 5);

        write_row(6, mem_pkg::ADDR_LOAD_STATE, 32'h6, 1'b0);
        for (int i = 0; i < 2; i++)
        begin
            write_row(6, mem_pkg::ADDR_BIAS_DATA, 32'h0, 1'b0);
            write_row(6, mem_pkg::ADDR_WEIGHT_DATA, 32'h0, 1'b0);
        end
        read_row(6, mem_pkg::ADDR_LOAD_STATE, 1'b0, 32'h6);
        write_row(6, mem_pkg::ADDR_CLEAR, 32'h1, 1'b0);
        read_row(6, mem_pkg::ADDR_STATUS, 1'b0, status_word(0, 0, 1, 0, 1));
        write_row(6, 8'h18, 32'h0, 1'b1);
        read_row(6, 8'h20, 1'b1, 32'h0);
        stream_row(6, 3'b110, 4);
        write_row(6, mem_pkg::ADDR_LOAD_STATE, 32'h0, 1'b0);
    endtask

    //////////////////////////////
    // Bus and stream drivers
    //////////////////////////////

    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] data, output logic err,
                                output logic [31:0] rdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        // Access phase sampled mid-cycle
        @(negedge clk);
        err   = pslverr;
        rdata = prdata;
        ready_check($sformatf("access to 0x%02h", addr), pready, 1'b1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        // Time for push, flags and registered status to settle
        repeat (2) @(posedge clk);
    endtask

    // Accepted writes feed the expected streams and a clear drops them
    task automatic track_write(input logic [7:0] addr, input logic [31:0] data);
        if (addr == mem_pkg::ADDR_BIAS_DATA)
            bias_exp.push_back(data[mem_pkg::DATA_W-1:0]);
        else if (addr == mem_pkg::ADDR_WEIGHT_DATA)
            weight_exp.push_back(data[mem_pkg::DATA_W-1:0]);
        else if (addr == mem_pkg::ADDR_LAYER_DATA)
            layer_exp.push_back(data[mem_pkg::DATA_W-1:0]);
        else if (addr == mem_pkg::ADDR_CLEAR)
        begin
            bias_exp.delete();
            weight_exp.delete();
            layer_exp.delete();
        end
    endtask

    task automatic leftover_check(input string what, input int left);
        if (left != 0)
        begin
            err_count++;
            $display("%s stream stopped with %0d words never delivered", what, left);
        end
    endtask

    task automatic run_stream(input mem_pkg::state_t state, input logic [7:0] hold);
        @(posedge clk);
        read_state <= state;
        repeat (hold) @(posedge clk);
        read_state <= '0;
        repeat (3) @(posedge clk);
        if (state[mem_pkg::STORE_BIAS])
            leftover_check("bias", bias_exp.size());
        if (state[mem_pkg::STORE_WEIGHT])
            leftover_check("weight", weight_exp.size());
        if (state[mem_pkg::STORE_LAYER])
            leftover_check("layer", layer_exp.size());
    endtask

    task automatic stray_word(input string what);
        err_count++;
        $display("%s stream delivered a word while none was expected", what);
    endtask

    //////////////////////////////
    // Stream monitor
    //////////////////////////////

    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (bias_valid)
            begin
                if (bias_exp.size() == 0)
                    stray_word("bias");
                else
                    stream_check("bias word", bias_q, bias_exp.pop_front());
            end
            if (weight_valid)
            begin
                if (weight_exp.size() == 0)
                    stray_word("weight");
                else
                    stream_check("weight word", weight_q, weight_exp.pop_front());
            end
            if (layer_valid)
            begin
                if (layer_exp.size() == 0)
                    stray_word("layer");
                else
                    stream_check("layer word", layer_q, layer_exp.pop_front());
            end
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        logic        err;
        logic [31:0] rdata;
        logic [31:0] wdata;
        int          mark;
        row_t        r;

        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        read_state = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        mark = 0;
        for (int i = 0; i < rows.size(); i++)
        begin
            r = rows[i];
            case (r.op)
                OP_WRITE:
                begin
                    wdata = is_data_addr(r.addr) ? $random(seed) : r.data;
                    apb_transfer(1'b1, r.addr, wdata, err, rdata);
                    slverr_check($sformatf("row %0d write", i), err, r.exp_err);
                    if (!r.exp_err)
                        track_write(r.addr, wdata);
                end
                OP_READ:
                begin
                    apb_transfer(1'b0, r.addr, 32'h0, err, rdata);
                    slverr_check($sformatf("row %0d read", i), err, r.exp_err);
                    if (!r.exp_err)
                        rdata_check($sformatf("row %0d", i), rdata, r.exp_rdata);
                end
                default:
                    run_stream(r.data[2:0], r.hold);
            endcase
            // Close out the test when its last row is done
            if (i == rows.size() - 1 || rows[i + 1].test != r.test)
            begin
                if (err_count == mark)
                    $display("test %0d %s: ok", r.test, test_name(r.test));
                else
                    $display("test %0d %s: %0d errors", r.test, test_name(r.test),
                             err_count - mark);
                mark = err_count;
            end
        end

        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Run budget of twenty cycles per table row
    initial
    begin
        wait (table_ready);
        #(rows.size() * 20 * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", rows.size() * 20);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== hw/cnn_mem_top.sv ====
`timescale 1ns/1ps

module cnn_mem_top #(
    parameter int BIAS_DEPTH   = 8,
    parameter int WEIGHT_DEPTH = 16,
    parameter int LAYER_DEPTH  = 32
) (
    input  logic                       clk,
    input  logic                       rst,

    // Host APB
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,

    // From the global controller
    input  mem_pkg::state_t            read_state,

    // Streams toward the compute array
    output logic [mem_pkg::DATA_W-1:0] bias_q,
    output logic                       bias_valid,
    output logic [mem_pkg::DATA_W-1:0] weight_q,
    output logic                       weight_valid,
    output logic [mem_pkg::DATA_W-1:0] layer_q,
    output logic                       layer_valid
);

    mem_pkg::state_t            load_state;
    mem_pkg::mem_state_t        memory_state;
    logic                       clear_req;
    logic                       load_done;
    logic                       bias_wr_ok;
    logic                       weight_wr_ok;
    logic                       layer_wr_ok;
    logic                       bias_push;
    logic                       weight_push;
    logic                       layer_push;
    logic [mem_pkg::DATA_W-1:0] push_data;
    logic                       bias_rd_en;
    logic                       weight_rd_en;
    logic                       layer_rd_en;
    logic                       bias_rst;
    logic                       weight_rst;
    logic                       layer_rst;
    logic                       bias_full;
    logic                       bias_empty;
    logic                       weight_full;
    logic                       weight_empty;

    //////////////////////////////
    // Host side
    //////////////////////////////

    apb_load_port u_port (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .bias_wr_ok   (bias_wr_ok),
        .weight_wr_ok (weight_wr_ok),
        .layer_wr_ok  (layer_wr_ok),
        .load_done    (load_done),
        .memory_state (memory_state),
        .load_state   (load_state),
        .clear_req    (clear_req),
        .bias_push    (bias_push),
        .weight_push  (weight_push),
        .layer_push   (layer_push),
        .push_data    (push_data)
    );

    memory_controller u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .load_state   (load_state),
        .read_state   (read_state),
        .clear_req    (clear_req),
        .bias_full    (bias_full),
        .bias_empty   (bias_empty),
        .weight_full  (weight_full),
        .weight_empty (weight_empty),
        .layer_push   (layer_push),
        .bias_wr_ok   (bias_wr_ok),
        .weight_wr_ok (weight_wr_ok),
        .layer_wr_ok  (layer_wr_ok),
        .bias_rd_en   (bias_rd_en),
        .weight_rd_en (weight_rd_en),
        .layer_rd_en  (layer_rd_en),
        .bias_rst     (bias_rst),
        .weight_rst   (weight_rst),
        .layer_rst    (layer_rst),
        .load_done    (load_done),
        .memory_state (memory_state)
    );

    //////////////////////////////
    // Stores
    //////////////////////////////

    param_fifo #(.DEPTH(BIAS_DEPTH), .WIDTH(mem_pkg::DATA_W)) u_bias_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (bias_rst),
        .push      (bias_push),
        .push_data (push_data),
        .rd_en     (bias_rd_en),
        .q         (bias_q),
        .q_valid   (bias_valid),
        .full      (bias_full),
        .empty     (bias_empty)
    );

    param_fifo #(.DEPTH(WEIGHT_DEPTH), .WIDTH(mem_pkg::DATA_W)) u_weight_fifo (
        .clk       (clk),
        .rst       (rst),
        .flush     (weight_rst),
        .push      (weight_push),
        .push_data (push_data),
        .rd_en     (weight_rd_en),
        .q         (weight_q),
        .q_valid   (weight_valid),
        .full      (weight_full),
        .empty     (weight_empty)
    );

    layer_buffer #(.DEPTH(LAYER_DEPTH), .WIDTH(mem_pkg::DATA_W)) u_layer_buf (
        .clk       (clk),
        .rst       (rst),
        .flush     (layer_rst),
        .push      (layer_push),
        .push_data (push_data),
        .rd_en     (layer_rd_en),
        .q         (layer_q),
        .q_valid   (layer_valid)
    );

endmodule

// ==== hw/apb_load_port.sv ====
`timescale 1ns/1ps

module apb_load_port (
    input  logic                       clk,
    input  logic                       rst,

    // APB slave
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,

    // Permissions and status from the memory controller
    input  logic                       bias_wr_ok,
    input  logic                       weight_wr_ok,
    input  logic                       layer_wr_ok,
    input  logic                       load_done,
    input  mem_pkg::mem_state_t        memory_state,

    // Toward controller and stores
    output mem_pkg::state_t            load_state,
    output logic                       clear_req,
    output logic                       bias_push,
    output logic                       weight_push,
    output logic                       layer_push,
    output logic [mem_pkg::DATA_W-1:0] push_data
);

    logic access;
    logic wr_access;
    logic sel_load;
    logic sel_bias;
    logic sel_weight;
    logic sel_layer;
    logic sel_status;
    logic sel_clear;
    logic addr_known;
    logic data_refused;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    assign sel_load   = (paddr == mem_pkg::ADDR_LOAD_STATE);
    assign sel_bias   = (paddr == mem_pkg::ADDR_BIAS_DATA);
    assign sel_weight = (paddr == mem_pkg::ADDR_WEIGHT_DATA);
    assign sel_layer  = (paddr == mem_pkg::ADDR_LAYER_DATA);
    assign sel_status = (paddr == mem_pkg::ADDR_STATUS);
    assign sel_clear  = (paddr == mem_pkg::ADDR_CLEAR);

    assign addr_known = sel_load || sel_bias || sel_weight || sel_layer
                        || sel_status || sel_clear;

    // Data write into a store that is not accepting
    assign data_refused = wr_access && ((sel_bias && !bias_wr_ok)
                                        || (sel_weight && !weight_wr_ok)
                                        || (sel_layer && !layer_wr_ok));

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && (!addr_known || data_refused);

    //////////////////////////////
    // Readback
    //////////////////////////////

    always_comb
    begin
        prdata = '0;
        if (sel_status)
        begin
            prdata[mem_pkg::STATUS_LOAD_DONE] = load_done;
            prdata[3:0] = memory_state;
        end
        else if (sel_load)
            prdata[2:0] = load_state;
    end

    //////////////////////////////
    // Writes
    //////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            load_state  <= '0;
            clear_req   <= 1'b0;
            bias_push   <= 1'b0;
            weight_push <= 1'b0;
            layer_push  <= 1'b0;
        end
        else
        begin
            // Strobes last a single cycle
            clear_req   <= wr_access && sel_clear;
            bias_push   <= wr_access && sel_bias && bias_wr_ok;
            weight_push <= wr_access && sel_weight && weight_wr_ok;
            layer_push  <= wr_access && sel_layer && layer_wr_ok;
            if (wr_access && sel_load)
                load_state <= pwdata[2:0];
        end
    end

    // Word travels alongside whichever strobe fires
    always_ff @(posedge clk)
    begin
        if (wr_access && (sel_bias || sel_weight || sel_layer))
            push_data <= pwdata[mem_pkg::DATA_W-1:0];
    end

endmodule

// ==== hw/layer_buffer.sv ====
`timescale 1ns/1ps

module layer_buffer #(
    parameter int DEPTH = 32,
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] q,
    output logic             q_valid
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_addr;
    logic [AW-1:0]    rd_addr;
    logic [AW-1:0]    addr;
    logic             do_read;

    function automatic logic [AW-1:0] bump(input logic [AW-1:0] a);
        return (a == AW'(DEPTH - 1)) ? '0 : a + 1'b1;
    endfunction

    // Loading owns the port whenever it asks
    assign do_read = rd_en && !push;
    assign addr    = push ? wr_addr : rd_addr;

    // One address, one access per cycle
    always_ff @(posedge clk)
    begin
        if (push)
            mem[addr] <= push_data;
        else if (do_read)
            q <= mem[addr];
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_addr <= '0;
            rd_addr <= '0;
            q_valid <= 1'b0;
        end
        else if (flush)
        begin
            wr_addr <= '0;
            rd_addr <= '0;
            q_valid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_addr <= bump(wr_addr);
            // Read side replays the layer in write order
            if (do_read)
                rd_addr <= bump(rd_addr);
            q_valid <= do_read;
        end
    end

endmodule

// ==== hw/param_fifo.sv ====
`timescale 1ns/1ps

module param_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 16
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] q,
    output logic             q_valid,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointer step with wrap at DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = rd_en && !empty;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            q_valid <= 1'b0;
        end
        else if (flush)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            q_valid <= 1'b0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= bump(wr_ptr);
            if (do_pop)
                rd_ptr <= bump(rd_ptr);
            q_valid <= do_pop;
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and output word
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
        if (do_pop)
            q <= mem[rd_ptr];
    end

endmodule

// ==== hw/memory_controller.sv ====
`timescale 1ns/1ps

module memory_controller (
    input  logic                clk,
    input  logic                rst,

    // State words from the host port and the global controller
    input  mem_pkg::state_t     load_state,
    input  mem_pkg::state_t     read_state,
    input  logic                clear_req,

    // Store flags
    input  logic                bias_full,
    input  logic                bias_empty,
    input  logic                weight_full,
    input  logic                weight_empty,
    input  logic                layer_push,

    // Write permissions back to the port
    output logic                bias_wr_ok,
    output logic                weight_wr_ok,
    output logic                layer_wr_ok,

    // Read enables toward the stores
    output logic                bias_rd_en,
    output logic                weight_rd_en,
    output logic                layer_rd_en,

    // Synchronous store flushes
    output logic                bias_rst,
    output logic                weight_rst,
    output logic                layer_rst,

    // Status
    output logic                load_done,
    output mem_pkg::mem_state_t memory_state
);

    logic flush_q;

    //////////////////////////////
    // Load decode
    //////////////////////////////

    // A FIFO refuses new words once full
    assign bias_wr_ok   = load_state[mem_pkg::STORE_BIAS] && !bias_full;
    assign weight_wr_ok = load_state[mem_pkg::STORE_WEIGHT] && !weight_full;
    assign layer_wr_ok  = load_state[mem_pkg::STORE_LAYER];

    //////////////////////////////
    // Read decode
    //////////////////////////////

    // Never pop an empty FIFO
    assign bias_rd_en   = read_state[mem_pkg::STORE_BIAS] && !bias_empty;
    assign weight_rd_en = read_state[mem_pkg::STORE_WEIGHT] && !weight_empty;

    // Single port, so a pending layer write wins the cycle
    assign layer_rd_en  = read_state[mem_pkg::STORE_LAYER] && !layer_push;

    //////////////////////////////
    // Flush and status
    //////////////////////////////

    assign bias_rst   = flush_q;
    assign weight_rst = flush_q;
    assign layer_rst  = flush_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            flush_q      <= 1'b0;
            load_done    <= 1'b1;
            // Both FIFOs come up empty
            memory_state <= 4'b0101;
        end
        else
        begin
            flush_q      <= clear_req;
            // Loading is finished once every load bit is down
            load_done    <= (load_state == '0);
            memory_state <= {bias_full, bias_empty, weight_full, weight_empty};
        end
    end

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

    //////////////////////////////
    // State word layout
    //////////////////////////////

    // One bit per store, same meaning in the load and read words
    localparam int STORE_BIAS   = 2;
    localparam int STORE_WEIGHT = 1;
    localparam int STORE_LAYER  = 0;

    typedef logic [2:0] state_t;

    // {bias_full, bias_empty, weight_full, weight_empty}
    typedef logic [3:0] mem_state_t;

    //////////////////////////////
    // APB register map
    //////////////////////////////

    localparam logic [7:0] ADDR_LOAD_STATE  = 8'h00;
    localparam logic [7:0] ADDR_BIAS_DATA   = 8'h04;
    localparam logic [7:0] ADDR_WEIGHT_DATA = 8'h08;
    localparam logic [7:0] ADDR_LAYER_DATA  = 8'h0C;
    localparam logic [7:0] ADDR_STATUS      = 8'h10;
    localparam logic [7:0] ADDR_CLEAR       = 8'h14;

    // Status readback, memory state sits in bits 3:0
    localparam int STATUS_LOAD_DONE = 4;

    //////////////////////////////
    // Data path
    //////////////////////////////

    // Parameter word width shared by all stores
    localparam int DATA_W = 16;

endpackage
